/* src.f */
common/sched_pkg.sv
pifo/pifo_calendar.sv
rtl/enqueue_agent.sv
rtl/queue_stats.sv
rtl/sched_top.sv
verif/sched_checker.sv
verif/tb_sched_top.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_sched_top
FILELIST   := src.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status follows the pass line in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* verif/tb_sched_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sched_top
    import sched_pkg::*;
();

    localparam int TABLE_LEN      = 49;
    localparam int TIMEOUT_CYCLES = TABLE_LEN * 20 + 200;

    typedef struct packed {
        logic [2:0] phase;
        pkt_t       pkt;
    } row_t;

    logic        axis_aclk;
    logic        rst;
    pkt_t        in_pkt;
    logic        in_valid;
    logic        in_ready;
    pkt_t        out_pkt [NUM_PORTS];
    port_mask_t  out_valid;
    port_mask_t  out_ready;
    depth_t      q_size [NUM_PORTS];
    port_stats_t stats [NUM_PORTS];

    row_t        stim [TABLE_LEN];
    int          n_rows;
    pkt_t        model_q [NUM_PORTS][$];
    int          exp_dropped [NUM_PORTS];
    int          exp_removed [NUM_PORTS];
    logic [15:0] lfsr_state;
    int          checks;
    int          errors;
    int          tests_failed;
    int          phase_base;

    sched_top uut (
        .axis_aclk (axis_aclk),
        .rst       (rst),
        .in_pkt    (in_pkt),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_pkt   (out_pkt),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .q_size    (q_size),
        .stats     (stats)
    );

    initial begin
        axis_aclk = 1'b0;
        forever #5 axis_aclk = ~axis_aclk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge axis_aclk);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    ////////////////////
    // stimulus helpers
    ////////////////////
    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic pkt_t make_pkt(input logic rv, input int dst, input int rank,
                                      input logic [31:0] data);
        pkt_t p;
        p.meta.rank_valid = rv;
        p.meta.dst_port   = PORT_WIDTH'(dst);
        p.meta.rank       = RANK_WIDTH'(rank);
        p.data            = data;
        return p;
    endfunction

    task automatic add_row(input int phase, input pkt_t pkt);
        stim[n_rows].phase = 3'(phase);
        stim[n_rows].pkt   = pkt;
        n_rows++;
    endtask

    task automatic build_table();
        int ranks [6];
        int dst;
        int rank;
        logic [31:0] data;
        ranks = '{5, 2, 7, 2, 5, 1};
        for (int i = 0; i < 6; i++) begin
            add_row(2, make_pkt(1'b1, 0, ranks[i], 32'h2000 + i));
        end
        for (int i = 0; i < 16; i++) begin
            dst  = int'(rand_bits(2));
            rank = int'(rand_bits(8));
            data = rand_bits(32);
            add_row(3, make_pkt(1'b1, dst, rank, data));
        end
        // ties on rank 0 among the first eight
        for (int i = 0; i < PIFO_DEPTH + 3; i++) begin
            add_row(4, make_pkt(1'b1, 2, (i * 5) % 7, 32'h4000 + i));
        end
        for (int i = 0; i < NUM_PORTS; i++) begin
            add_row(5, make_pkt(1'b0, i, 10 * i, 32'h5000 + i));
        end
        for (int i = 0; i < 12; i++) begin
            add_row(6, make_pkt(i % 5 != 4, i % 4, (i * 3) % 8, 32'h6000 + i));
        end
    endtask

    ////////////////////
    // reference model
    ////////////////////
    task automatic model_accept(input int phase, input pkt_t pkt);
        int p;
        int pos;
        p = int'(pkt.meta.dst_port);
        if (!pkt.meta.rank_valid) begin
            exp_dropped[p]++;
        end else if (phase == 6) begin
            // drained as it arrives
            exp_removed[p]++;
        end else if (model_q[p].size() == PIFO_DEPTH) begin
            exp_dropped[p]++;
        end else begin
            pos = 0;
            while (pos < model_q[p].size() && model_q[p][pos].meta.rank <= pkt.meta.rank) begin
                pos++;
            end
            model_q[p].insert(pos, pkt);
        end
    endtask

    ////////////////////
    // compare tasks
    ////////////////////
    task automatic check_pkt(input pkt_t got, input pkt_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_depth(input depth_t got, input depth_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, depth %0d expected %0d", $time, msg, got, exp);
        end
    endtask

    task automatic check_stats(input port_stats_t got, input port_stats_t exp,
                               input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, dropped/removed %0d/%0d expected %0d/%0d",
                     $time, msg, got.dropped, got.removed, exp.dropped, exp.removed);
        end
    endtask

    task automatic check_mask(input port_mask_t got, input port_mask_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, msg, got, exp);
        end
    endtask

    // depth and counters of every port against the model
    task automatic check_all(input string msg);
        port_stats_t exp_st;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_st.dropped = CNT_WIDTH'(exp_dropped[p]);
            exp_st.removed = CNT_WIDTH'(exp_removed[p]);
            check_depth(q_size[p], depth_t'(model_q[p].size()), $sformatf("%s port %0d", msg, p));
            check_stats(stats[p], exp_st, $sformatf("%s port %0d", msg, p));
        end
    endtask

    ////////////////////
    // sequencing
    ////////////////////
    task automatic send_pkt(input pkt_t pkt);
        @(posedge axis_aclk);
        in_pkt   <= pkt;
        in_valid <= 1'b1;
    endtask

    task automatic drain_port(input int p);
        pkt_t exp;
        @(posedge axis_aclk);
        out_ready[p] <= 1'b1;
        while (model_q[p].size() > 0) begin
            @(negedge axis_aclk);
            if (out_valid[p]) begin
                exp = model_q[p].pop_front();
                check_pkt(out_pkt[p], exp, $sformatf("drain port %0d", p));
                exp_removed[p]++;
            end
        end
        @(posedge axis_aclk);
        out_ready[p] <= 1'b0;
    endtask

    function automatic string phase_name(input int phase);
        case (phase)
            2:       return "priority order";
            3:       return "port separation";
            4:       return "full drop";
            5:       return "rank-invalid drop";
            default: return "concurrent flow";
        endcase
    endfunction

    task automatic report_test(input int num, input string name, input int base);
        if (errors == base) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errors - base);
        end
    endtask

    task automatic start_phase(input int phase);
        phase_base = errors;
        if (phase == 6) begin
            @(posedge axis_aclk);
            out_ready <= '1;
        end
    endtask

    task automatic finish_phase(input int phase);
        @(posedge axis_aclk);
        in_valid <= 1'b0;
        // accept, decide, insert
        repeat (3) @(posedge axis_aclk);
        @(negedge axis_aclk);
        case (phase)
            2, 4: begin
                check_all("before drain");
                drain_port(phase == 2 ? 0 : 2);
            end
            3: begin
                for (int p = 0; p < NUM_PORTS; p++) begin
                    drain_port(p);
                end
            end
            5: check_mask(out_valid, '0, "out_valid after invalid ranks");
            default: begin
                @(posedge axis_aclk);
                out_ready <= '0;
            end
        endcase
        @(negedge axis_aclk);
        check_all(phase_name(phase));
        report_test(phase, phase_name(phase), phase_base);
    endtask

    initial begin
        int base;
        rst          = 1'b1;
        in_pkt       = '0;
        in_valid     = 1'b0;
        out_ready    = '0;
        lfsr_state   = 16'd4365;
        n_rows       = 0;
        checks       = 0;
        errors       = 0;
        tests_failed = 0;
        phase_base   = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_dropped[p] = 0;
            exp_removed[p] = 0;
        end
        build_table();
        repeat (2) @(posedge axis_aclk);
        rst <= 1'b0;

        base = errors;
        // in_ready comes up one cycle after reset is released
        @(posedge axis_aclk);
        @(negedge axis_aclk);
        check_bit(in_ready, 1'b1, "in_ready after reset");
        check_mask(out_valid, '0, "out_valid after reset");
        check_all("after reset");
        report_test(1, "reset state", base);

        for (int i = 0; i < TABLE_LEN; i++) begin
            if (i == 0 || stim[i].phase != stim[i-1].phase) begin
                start_phase(int'(stim[i].phase));
            end
            send_pkt(stim[i].pkt);
            model_accept(int'(stim[i].phase), stim[i].pkt);
            if (i == TABLE_LEN - 1 || stim[i+1].phase != stim[i].phase) begin
                finish_phase(int'(stim[i].phase));
            end
        end

        $display("6 tests, %0d failed, %0d checks, %0d errors", tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/sched_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module sched_checker
    import sched_pkg::*;
(
    input logic       axis_aclk,
    input logic       rst,
    input logic       in_ready,
    input port_mask_t out_valid,
    input depth_t     q_size [NUM_PORTS],
    input port_mask_t ins_en,
    input port_mask_t drop_en
);

    // input side held off for the first cycle out of reset
    a_ready_after_rst: assert property (@(posedge axis_aclk) rst |=> !in_ready)
        else $error("in_ready high in the cycle after reset");

    generate
        for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
            a_valid_depth: assert property (@(posedge axis_aclk) disable iff (rst)
                out_valid[p] |-> q_size[p] != '0)
                else $error("out_valid set on an empty queue");
        end
    endgenerate

    ////////////////////
    // decision stage
    ////////////////////
    a_onehot: assert property (@(posedge axis_aclk) disable iff (rst)
        $onehot0(ins_en) && $onehot0(drop_en))
        else $error("insert or drop strobe not one-hot");

    a_no_overlap: assert property (@(posedge axis_aclk) disable iff (rst)
        (ins_en & drop_en) == '0)
        else $error("insert and drop raised together");

endmodule

bind sched_top sched_checker checker_inst (
    .axis_aclk (axis_aclk),
    .rst       (rst),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .q_size    (q_size),
    .ins_en    (ins_en),
    .drop_en   (drop_en)
);

`default_nettype wire

/* rtl/sched_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sched_top
    import sched_pkg::*;
(
    input  logic             axis_aclk,
    input  logic             rst,

    // ingress stream
    input  pkt_t             in_pkt,
    input  logic             in_valid,
    output logic             in_ready,

    // one egress stream per port
    output wire pkt_t        out_pkt [NUM_PORTS],
    output wire port_mask_t  out_valid,
    input  port_mask_t       out_ready,

    // status
    output wire depth_t      q_size [NUM_PORTS],
    output port_stats_t      stats [NUM_PORTS]
);

    wire port_mask_t full;
    port_mask_t      ins_en;
    port_mask_t      drop_en;
    port_mask_t      pop;
    pkt_t            ins_pkt;

    // a packet leaves on valid and ready
    assign pop = out_valid & out_ready;

    ////////////////////
    // admission
    ////////////////////
    enqueue_agent enqueue_agent_inst (
        .axis_aclk (axis_aclk),
        .rst       (rst),
        .in_pkt    (in_pkt),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .full      (full),
        .ins_en    (ins_en),
        .ins_pkt   (ins_pkt),
        .drop_en   (drop_en)
    );

    ////////////////////
    // per-port calendars
    ////////////////////
    generate
        for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
            pifo_calendar pifo_inst (
                .axis_aclk (axis_aclk),
                .rst       (rst),
                .ins_en    (ins_en[p]),
                .ins_pkt   (ins_pkt),
                .pop       (pop[p]),
                .head      (out_pkt[p]),
                .out_valid (out_valid[p]),
                .full      (full[p]),
                .count     (q_size[p])
            );
        end
    endgenerate

    // drop and removal counters
    queue_stats queue_stats_inst (
        .axis_aclk (axis_aclk),
        .rst       (rst),
        .drop_en   (drop_en),
        .pop       (pop),
        .stats     (stats)
    );

endmodule

`default_nettype wire

/* rtl/queue_stats.sv */
`timescale 1ns/1ps
`default_nettype none

module queue_stats
    import sched_pkg::*;
(
    input  logic        axis_aclk,
    input  logic        rst,

    // one pulse per dropped or removed packet
    input  port_mask_t  drop_en,
    input  port_mask_t  pop,

    output port_stats_t stats [NUM_PORTS]
);

    logic [CNT_WIDTH-1:0] dropped_q [NUM_PORTS];
    logic [CNT_WIDTH-1:0] removed_q [NUM_PORTS];

    ////////////////////
    // counters
    ////////////////////
    generate
        for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
            // wrap silently
            always_ff @(posedge axis_aclk) begin
                if (rst) begin
                    dropped_q[p] <= '0;
                end else if (drop_en[p]) begin
                    dropped_q[p] <= dropped_q[p] + CNT_WIDTH'(1);
                end
            end

            always_ff @(posedge axis_aclk) begin
                if (rst) begin
                    removed_q[p] <= '0;
                end else if (pop[p]) begin
                    removed_q[p] <= removed_q[p] + CNT_WIDTH'(1);
                end
            end

            assign stats[p] = '{dropped: dropped_q[p], removed: removed_q[p]};
        end
    endgenerate

endmodule

`default_nettype wire

/* rtl/enqueue_agent.sv */
`timescale 1ns/1ps
`default_nettype none

module enqueue_agent
    import sched_pkg::*;
(
    input  logic       axis_aclk,
    input  logic       rst,

    input  pkt_t       in_pkt,
    input  logic       in_valid,
    output logic       in_ready,

    // calendar status, one bit per port
    input  port_mask_t full,

    // one-hot insert or drop for the registered packet
    output port_mask_t ins_en,
    output pkt_t       ins_pkt,
    output port_mask_t drop_en
);

    logic       ready_q;
    logic       pkt_vld;
    pkt_t       pkt_q;
    port_mask_t dst_mask;
    logic       keep;

    // never back-pressures once out of reset
    assign in_ready = ready_q;

    always_ff @(posedge axis_aclk) begin
        if (rst) begin
            ready_q <= 1'b0;
            pkt_vld <= 1'b0;
        end else begin
            ready_q <= 1'b1;
            pkt_vld <= in_valid & ready_q;
        end
    end

    always_ff @(posedge axis_aclk) begin
        if (in_valid && ready_q) begin
            pkt_q <= in_pkt;
        end
    end

    ////////////////////
    // decision stage
    ////////////////////
    assign dst_mask = port_mask_t'(1) << pkt_q.meta.dst_port;

    // full is sampled in the deciding cycle
    assign keep = pkt_q.meta.rank_valid & ~full[pkt_q.meta.dst_port];

    assign ins_en  = (pkt_vld && keep)  ? dst_mask : '0;
    assign drop_en = (pkt_vld && !keep) ? dst_mask : '0;
    assign ins_pkt = pkt_q;

endmodule

`default_nettype wire

/* pifo/pifo_calendar.sv */
`timescale 1ns/1ps
`default_nettype none

module pifo_calendar
    import sched_pkg::*;
(
    input  logic   axis_aclk,
    input  logic   rst,

    input  logic   ins_en,
    input  pkt_t   ins_pkt,
    input  logic   pop,

    // entry 0 is the lowest rank
    output pkt_t   head,
    output logic   out_valid,
    output logic   full,
    output depth_t count
);

    pkt_t                  slot     [PIFO_DEPTH];
    pkt_t                  slot_up  [PIFO_DEPTH];
    pkt_t                  slot_dn  [PIFO_DEPTH];
    pkt_t                  slot_nxt [PIFO_DEPTH];
    logic [PIFO_DEPTH-1:0] rank_le;
    depth_t                ins_pos;
    depth_t                ins_idx;
    logic                  ins_ok;
    logic                  pop_ok;

    assign full      = (count == depth_t'(PIFO_DEPTH));
    assign out_valid = (count != '0);
    assign head      = slot[0];

    // full is judged on the count at the start of the cycle
    assign ins_ok = ins_en & ~full;
    assign pop_ok = pop & out_valid;

    ////////////////////
    // per-slot compare
    ////////////////////
    generate
        for (genvar i = 0; i < PIFO_DEPTH; i++) begin : g_slot
            // held entries at or below the new rank stay ahead of it
            assign rank_le[i] = (depth_t'(i) < count) &&
                                (slot[i].meta.rank <= ins_pkt.meta.rank);

            // neighbours for shifting back and forward
            if (i == 0) begin : g_first
                assign slot_dn[i] = ins_pkt;
            end else begin : g_dn
                assign slot_dn[i] = slot[i-1];
            end

            if (i == PIFO_DEPTH - 1) begin : g_last
                assign slot_up[i] = ins_pkt;
            end else begin : g_up
                assign slot_up[i] = slot[i+1];
            end
        end
    endgenerate

    // entries are sorted, so rank_le is a prefix and its popcount is the landing slot
    always_comb begin
        ins_pos = '0;
        for (int i = 0; i < PIFO_DEPTH; i++) begin
            ins_pos = ins_pos + depth_t'(rank_le[i]);
        end
        // head leaves this cycle, so everything sits one place further up
        if (pop_ok && ins_pos != '0) begin
            ins_idx = ins_pos - depth_t'(1);
        end else begin
            ins_idx = ins_pos;
        end
    end

    ////////////////////
    // next contents
    ////////////////////
    always_comb begin
        for (int i = 0; i < PIFO_DEPTH; i++) begin
            if (ins_ok && depth_t'(i) == ins_idx) begin
                slot_nxt[i] = ins_pkt;
            end else if (pop_ok) begin
                // shift forward up to the new entry
                slot_nxt[i] = (ins_ok && depth_t'(i) > ins_idx) ? slot[i] : slot_up[i];
            end else begin
                // make room behind the new entry
                slot_nxt[i] = (ins_ok && depth_t'(i) > ins_idx) ? slot_dn[i] : slot[i];
            end
        end
    end

    always_ff @(posedge axis_aclk) begin
        for (int i = 0; i < PIFO_DEPTH; i++) begin
            slot[i] <= slot_nxt[i];
        end
    end

    // occupancy
    always_ff @(posedge axis_aclk) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= count + depth_t'(ins_ok) - depth_t'(pop_ok);
        end
    end

endmodule

`default_nettype wire

/* common/sched_pkg.sv */
`default_nettype none

package sched_pkg;

    ////////////////////
    // sizes
    ////////////////////
    localparam int NUM_PORTS   = 4;
    localparam int DATA_WIDTH  = 32;
    localparam int RANK_WIDTH  = 8;
    localparam int PORT_WIDTH  = 2;
    localparam int PIFO_DEPTH  = 8;
    // holds 0 to PIFO_DEPTH
    localparam int DEPTH_WIDTH = 4;
    localparam int CNT_WIDTH   = 16;

    ////////////////////
    // types
    ////////////////////
    typedef logic [NUM_PORTS-1:0]   port_mask_t;
    typedef logic [DEPTH_WIDTH-1:0] depth_t;

    // scheduling info carried next to the data word
    typedef struct packed {
        logic                  rank_valid;
        logic [PORT_WIDTH-1:0] dst_port;
        logic [RANK_WIDTH-1:0] rank;
    } meta_t;

    // single-beat packet
    typedef struct packed {
        meta_t                 meta;
        logic [DATA_WIDTH-1:0] data;
    } pkt_t;

    typedef struct packed {
        logic [CNT_WIDTH-1:0] dropped;
        logic [CNT_WIDTH-1:0] removed;
    } port_stats_t;

endpackage

`default_nettype wire
